// File: rtl/exec_pkg.sv
// Shared definitions for the RV32I execute stage
// Holds the data and tag widths, the operation codes and the port structs
// Every stage module takes these through a wildcard import in its header

`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int TAG_W   = 3;
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [XLEN/8-1:0] byte_en_t;

    // Return address is the instruction after the jump
    localparam word_t LINK_OFFSET = word_t'(4);

    ////////////////////////////////////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } exec_op_e;

    ////////////////////////////////////////////////////////////////////////
    // Port bundles
    ////////////////////////////////////////////////////////////////////////

    // Decoded instruction as it leaves the decode stage
    typedef struct packed {
        exec_op_e op;
        word_t    pc;
        word_t    first_operand;
        word_t    second_operand;
        // Store data or branch offset
        word_t    third_operand;
        tag_t     tag;
    } exec_in_t;

    typedef struct packed {
        word_t    addr;
        logic     read_en;
        byte_en_t write_en;
        word_t    write_data;
    } mem_req_t;

    typedef struct packed {
        logic  jump;
        word_t target;
    } jump_req_t;

    typedef struct packed {
        logic     write_en;
        exec_op_e op;
        word_t    result;
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/alu_unit.sv
// Integer datapath of the execute stage
// Produces the writeback value for arithmetic, logic, shift, compare,
// LUI and link operations; loads and unknown ops fall back to the sum

`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import exec_pkg::*;
(
    input  wire exec_in_t instr_i,
    output word_t         result_o
);

    logic signed [XLEN-1:0] first_signed;
    logic signed [XLEN-1:0] second_signed;
    logic [SHAMT_W-1:0]     shamt;

    word_t sum_result;
    word_t diff_result;
    word_t and_result;
    word_t or_result;
    word_t xor_result;
    word_t sll_result;
    word_t srl_result;
    word_t sra_result;
    word_t link_result;
    logic  less_signed;
    logic  less_unsigned;

    assign first_signed  = instr_i.first_operand;
    assign second_signed = instr_i.second_operand;

    // Only the low bits of the second operand count as shift amount
    assign shamt = instr_i.second_operand[SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////////////////
    // Functional units
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_result  = instr_i.first_operand + instr_i.second_operand;
        diff_result = instr_i.first_operand - instr_i.second_operand;
        and_result  = instr_i.first_operand & instr_i.second_operand;
        or_result   = instr_i.first_operand | instr_i.second_operand;
        xor_result  = instr_i.first_operand ^ instr_i.second_operand;
    end

    always_comb begin
        sll_result = instr_i.first_operand << shamt;
        srl_result = instr_i.first_operand >> shamt;
        // Arithmetic shift keeps the sign of the first operand
        sra_result = word_t'(first_signed >>> shamt);
    end

    assign less_signed   = first_signed < second_signed;
    assign less_unsigned = instr_i.first_operand < instr_i.second_operand;

    assign link_result = instr_i.pc + LINK_OFFSET;

    ////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (instr_i.op)
            SUB: begin
                result_o = diff_result;
            end
            AND: begin
                result_o = and_result;
            end
            OR: begin
                result_o = or_result;
            end
            XOR: begin
                result_o = xor_result;
            end
            SLL: begin
                result_o = sll_result;
            end
            SRL: begin
                result_o = srl_result;
            end
            SRA: begin
                result_o = sra_result;
            end
            SLT: begin
                result_o = {{(XLEN-1){1'b0}}, less_signed};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            end
            // Immediate arrives already shifted from decode
            LUI: begin
                result_o = instr_i.second_operand;
            end
            JAL, JALR: begin
                result_o = link_result;
            end
            // ADD, loads and everything else
            default: begin
                result_o = sum_result;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/branch_control.sv
// Branch and jump decision for the execute stage
// Evaluates the branch condition, forms the jump target and keeps the
// flow tag; instructions whose tag is stale are flagged as killed

`timescale 1ns/1ps
`default_nettype none

module branch_control
    import exec_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_n,
    input  wire exec_in_t instr_i,
    output jump_req_t     jump_o,
    output logic          killed_o
);

    tag_t  curr_tag;
    word_t branch_target;
    word_t reg_target;
    logic  equal;
    logic  less_signed;
    logic  less_unsigned;
    logic  greater_equal_signed;
    logic  greater_equal_unsigned;
    logic  taken;

    ////////////////////////////////////////////////////////////////////////
    // Condition evaluation
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        equal                  = instr_i.first_operand == instr_i.second_operand;
        less_signed            = $signed(instr_i.first_operand)
                                 < $signed(instr_i.second_operand);
        less_unsigned          = instr_i.first_operand < instr_i.second_operand;
        greater_equal_signed   = $signed(instr_i.first_operand)
                                 >= $signed(instr_i.second_operand);
        greater_equal_unsigned = instr_i.first_operand >= instr_i.second_operand;
    end

    always_comb begin
        unique case (instr_i.op)
            BEQ:       taken = equal;
            BNE:       taken = ~equal;
            BLT:       taken = less_signed;
            BLTU:      taken = less_unsigned;
            BGE:       taken = greater_equal_signed;
            BGEU:      taken = greater_equal_unsigned;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Jump target
    ////////////////////////////////////////////////////////////////////////

    // Branch offset travels in the third operand
    assign branch_target = instr_i.pc + instr_i.third_operand;
    assign reg_target    = instr_i.first_operand + instr_i.second_operand;

    always_comb begin
        unique case (instr_i.op)
            JAL:     jump_o.target = reg_target;
            JALR:    jump_o.target = {reg_target[XLEN-1:1], 1'b0};
            default: jump_o.target = branch_target;
        endcase
    end

    // Wrong-path instructions must not redirect fetch
    assign jump_o.jump = taken & ~killed_o;

    ////////////////////////////////////////////////////////////////////////
    // Flow tag
    ////////////////////////////////////////////////////////////////////////

    assign killed_o = curr_tag != instr_i.tag;

    // Advances on every taken jump, stalled or not
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump_o.jump) begin
            curr_tag <= curr_tag + tag_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/store_align.sv
// Load/store request generation for the execute stage
// Drives a word-aligned address, the load read enable, the byte write
// enables and store data replicated across the byte lanes

`timescale 1ns/1ps
`default_nettype none

module store_align
    import exec_pkg::*;
(
    input  wire exec_in_t instr_i,
    output mem_req_t      mem_o
);

    word_t    eff_addr;
    logic [1:0] lane;
    byte_en_t byte_en;

    assign eff_addr = instr_i.first_operand + instr_i.second_operand;

    // Low address bits pick the lanes inside the word
    assign lane = eff_addr[1:0];

    ////////////////////////////////////////////////////////////////////////
    // Address and read enable
    ////////////////////////////////////////////////////////////////////////

    assign mem_o.addr    = {eff_addr[XLEN-1:2], 2'b00};
    assign mem_o.read_en = instr_i.op inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (instr_i.op)
            SB: begin
                unique case (lane)
                    2'b11:   byte_en = 4'b1000;
                    2'b10:   byte_en = 4'b0100;
                    2'b01:   byte_en = 4'b0010;
                    default: byte_en = 4'b0001;
                endcase
            end
            // Halfword lands in the upper or lower half
            SH: begin
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    assign mem_o.write_en = byte_en;

    ////////////////////////////////////////////////////////////////////////
    // Write data
    ////////////////////////////////////////////////////////////////////////

    // Memory picks the lane it needs from the replicated data
    always_comb begin
        unique case (instr_i.op)
            SB:      mem_o.write_data = {(XLEN/8){instr_i.third_operand[7:0]}};
            SH:      mem_o.write_data = {(XLEN/16){instr_i.third_operand[15:0]}};
            default: mem_o.write_data = instr_i.third_operand;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage of the in-order RV32I pipeline
// Connects the ALU, branch control and load/store units; jump, kill and
// memory outputs are combinational, writeback is registered once per
// cycle and held while stall_i is high

`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import exec_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_n,
    input  wire logic     stall_i,
    input  wire exec_in_t instr_i,
    output jump_req_t     jump_o,
    output logic          killed_o,
    output mem_req_t      mem_o,
    output wb_t           wb_o
);

    word_t alu_result;
    logic  killed;
    logic  write_en;
    wb_t   wb_next;

    ////////////////////////////////////////////////////////////////////////
    // Units
    ////////////////////////////////////////////////////////////////////////

    alu_unit alu_unit_i (
        .instr_i  (instr_i),
        .result_o (alu_result)
    );

    branch_control branch_control_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .instr_i  (instr_i),
        .jump_o   (jump_o),
        .killed_o (killed)
    );

    // Memory request goes out even for killed instructions
    store_align store_align_i (
        .instr_i (instr_i),
        .mem_o   (mem_o)
    );

    assign killed_o = killed;

    ////////////////////////////////////////////////////////////////////////
    // Write enable
    ////////////////////////////////////////////////////////////////////////

    // Stores and branches have no destination register
    always_comb begin
        unique case (instr_i.op)
            SB, SH, SW,
            BEQ, BNE,
            BLT, BLTU,
            BGE, BGEU: begin
                write_en = 1'b0;
            end
            default: begin
                write_en = ~killed;
            end
        endcase
    end

    always_comb begin
        wb_next.write_en = write_en;
        wb_next.op       = instr_i.op;
        wb_next.result   = alu_result;
    end

    ////////////////////////////////////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o.write_en <= 1'b0;
            wb_o.op       <= NOP;
            wb_o.result   <= '0;
        end else if (!stall_i) begin
            wb_o <= wb_next;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_execute_stage.sv
// Directed testbench for the execute stage
// Drives decoded instructions into the DUT and checks the jump, kill,
// memory and writeback outputs against reference rules

`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage
    import exec_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    // Reset, then the cycles of each test in the order they run
    localparam int TEST_CYCLES = 8 + 1 + 54 + 20 + 13 + 32 + 6;
    localparam int MARGIN      = 60;
    localparam word_t SIGN_BIT = {1'b1, {(XLEN-1){1'b0}}};
    localparam word_t ALL_ONES = {XLEN{1'b1}};

    logic      clk;
    logic      reset_n;
    logic      stall_i;
    exec_in_t  instr;
    jump_req_t jump;
    logic      killed;
    mem_req_t  mem;
    wb_t       wb;
    tag_t      exp_tag;

    execute_stage execute_stage_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .stall_i  (stall_i),
        .instr_i  (instr),
        .jump_o   (jump),
        .killed_o (killed),
        .mem_o    (mem),
        .wb_o     (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        stop_on_failure();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "Stopping the run after a failure");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_jump(input string name, input jump_req_t exp, input jump_req_t act);
        if (act !== exp) begin
            $display("** Error %s: expected jump=%b target=%h, actual jump=%b target=%h",
                     name, exp.jump, exp.target, act.jump, act.target);
            stop_on_failure();
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
        if (act !== exp) begin
            $display({"** Error %s: expected addr=%h rd=%b we=%b data=%h,",
                      " actual addr=%h rd=%b we=%b data=%h"},
                     name, exp.addr, exp.read_en, exp.write_en, exp.write_data,
                     act.addr, act.read_en, act.write_en, act.write_data);
            stop_on_failure();
        end
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            $display({"** Error %s: expected we=%b op=%0d result=%h,",
                      " actual we=%b op=%0d result=%h"},
                     name, exp.write_en, exp.op, exp.result, act.write_en, act.op, act.result);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////

    // Flipping the sign bits turns a signed compare into an unsigned one
    function automatic logic signed_less(input word_t a, input word_t b);
        return (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
    endfunction

    function automatic logic is_control(input exec_op_e op);
        return op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR};
    endfunction

    function automatic word_t exp_result(input exec_in_t in);
        word_t       a;
        word_t       b;
        int unsigned s;
        a = in.first_operand;
        b = in.second_operand;
        s = b % XLEN;
        case (in.op)
            SUB:       return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << s;
            SRL:       return a >> s;
            // Logical shift with the vacated bits filled by the sign
            SRA:       return (a >> s) | (a[XLEN-1] ? ~(ALL_ONES >> s) : word_t'(0));
            SLT:       return word_t'(signed_less(a, b));
            SLTU:      return word_t'(a < b);
            LUI:       return b;
            JAL, JALR: return in.pc + LINK_OFFSET;
            default:   return a + b;
        endcase
    endfunction

    function automatic jump_req_t exp_jump(input exec_in_t in, input logic kill);
        jump_req_t j;
        word_t     a;
        word_t     b;
        logic      taken;
        a = in.first_operand;
        b = in.second_operand;
        j.target = in.pc + in.third_operand;
        case (in.op)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = signed_less(a, b);
            BGE:     taken = !signed_less(a, b);
            BLTU:    taken = (a < b);
            BGEU:    taken = !(a < b);
            JAL: begin
                taken    = 1'b1;
                j.target = a + b;
            end
            JALR: begin
                taken    = 1'b1;
                j.target = (a + b) & ~word_t'(1);
            end
            default: taken = 1'b0;
        endcase
        j.jump = taken && !kill;
        return j;
    endfunction

    function automatic mem_req_t exp_mem(input exec_in_t in);
        mem_req_t m;
        word_t    sum;
        sum = in.first_operand + in.second_operand;
        m.addr       = sum & ~word_t'(3);
        m.read_en    = in.op inside {LB, LBU, LH, LHU, LW};
        m.write_data = in.third_operand;
        case (in.op)
            SB: begin
                m.write_en   = byte_en_t'(1) << sum[1:0];
                m.write_data = {4{in.third_operand[7:0]}};
            end
            SH: begin
                m.write_en   = sum[1] ? 4'b1100 : 4'b0011;
                m.write_data = {2{in.third_operand[15:0]}};
            end
            SW:      m.write_en = 4'b1111;
            default: m.write_en = 4'b0000;
        endcase
        return m;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Entered and left 2 ns after a rising edge
    task automatic run_instr(input string name, input exec_op_e op, input word_t pc,
                             input word_t a, input word_t b, input word_t c,
                             input tag_t tag);
        exec_in_t  in;
        jump_req_t ej;
        wb_t       ew;
        logic      kill;
        in.op             = op;
        in.pc             = pc;
        in.first_operand  = a;
        in.second_operand = b;
        in.third_operand  = c;
        in.tag            = tag;
        instr = in;
        kill  = (tag != exp_tag);
        ej    = exp_jump(in, kill);
        #4;
        check_flag({name, " killed"}, kill, killed);
        if (is_control(op)) begin
            check_jump({name, " jump"}, ej, jump);
        end else begin
            check_flag({name, " jump"}, 1'b0, jump.jump);
        end
        check_mem({name, " mem"}, exp_mem(in), mem);
        ew.write_en = !kill && !(op inside {SB, SH, SW}) && !(is_control(op) && op != JAL
                      && op != JALR);
        ew.op       = op;
        ew.result   = exp_result(in);
        @(posedge clk);
        #2;
        if (ej.jump) begin
            exp_tag = exp_tag + tag_t'(1);
        end
        check_wb({name, " wb"}, ew, wb);
    endtask

    task automatic test_reset();
        wb_t ew;
        ew.write_en = 1'b0;
        ew.op       = NOP;
        ew.result   = '0;
        check_wb("reset", ew, wb);
        run_instr("reset nop", NOP, 32'h0, 32'h11, 32'h22, 32'h0, tag_t'(0));
    endtask

    task automatic test_alu();
        exec_op_e ops[13] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
                              SLT, SLTU, LUI, JAL, JALR};
        word_t    a;
        word_t    b;
        foreach (ops[k]) begin
            for (int i = 0; i < 4; i++) begin
                a = $urandom;
                b = $urandom;
                // Negative first operand, then operands of opposite sign
                if (i == 0) begin
                    a[XLEN-1] = 1'b1;
                end else if (i == 1) begin
                    a = ~b;
                end
                run_instr("alu", ops[k], $urandom, a, b, $urandom, exp_tag);
            end
        end
        run_instr("slt neg", SLT, 32'h0, ALL_ONES, 32'h1, 32'h0, exp_tag);
        run_instr("sltu neg", SLTU, 32'h0, ALL_ONES, 32'h1, 32'h0, exp_tag);
    endtask

    task automatic test_branch();
        exec_op_e br[6] = '{BEQ, BNE, BLT, BLTU, BGE, BGEU};
        word_t    lhs[3] = '{32'd5, 32'd5, 32'hffff_fffd};
        word_t    rhs[3] = '{32'd5, 32'd7, 32'd2};
        foreach (br[k]) begin
            for (int i = 0; i < 3; i++) begin
                run_instr("branch", br[k], $urandom, lhs[i], rhs[i], $urandom, exp_tag);
            end
        end
        run_instr("jal", JAL, 32'h400, 32'h1000, 32'h35, 32'h0, exp_tag);
        run_instr("jalr", JALR, 32'h404, 32'h2000, 32'h13, 32'h0, exp_tag);
    endtask

    task automatic test_kill();
        tag_t start;
        start = exp_tag;
        run_instr("kill jal", JAL, 32'h800, 32'h100, 32'h0, 32'h0, exp_tag);
        run_instr("kill add", ADD, 32'h804, 32'h1, 32'h2, 32'h0, start);
        run_instr("kill jalr", JALR, 32'h808, 32'h300, 32'h0, 32'h0, start);
        run_instr("new tag", ADD, 32'h900, 32'h5, 32'h6, 32'h0, exp_tag);
        start = exp_tag;
        repeat (8) begin
            run_instr("wrap jal", JAL, $urandom, $urandom, $urandom, 32'h0, exp_tag);
        end
        run_instr("wrapped", OR, 32'h0, 32'h0f0, 32'h00f, 32'h0, start);
    endtask

    task automatic test_mem();
        exec_op_e ops[8] = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
        word_t    base;
        for (int off = 0; off < 4; off++) begin
            foreach (ops[k]) begin
                base = $urandom & ~word_t'(3);
                run_instr("mem", ops[k], $urandom, base, word_t'(off), $urandom, exp_tag);
            end
        end
    endtask

    task automatic test_stall();
        wb_t held;
        run_instr("pre stall", ADD, 32'h100, 32'h1234, 32'h1111, 32'h0, exp_tag);
        // Writeback of the ADD above must stay in place
        held.write_en = 1'b1;
        held.op       = ADD;
        held.result   = 32'h2345;
        stall_i = 1'b1;
        repeat (4) begin
            instr.op             = SUB;
            instr.first_operand  = $urandom;
            instr.second_operand = $urandom;
            instr.tag            = exp_tag;
            @(posedge clk);
            #2;
            check_wb("stall hold", held, wb);
        end
        stall_i = 1'b0;
        run_instr("after stall", XOR, 32'h200, 32'hff00, 32'h0ff0, 32'h0, exp_tag);
    endtask

    initial begin
        void'($urandom(32'he91d));
        reset_n = 1'b0;
        stall_i = 1'b0;
        instr   = '0;
        exp_tag = '0;
        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_reset();
        test_alu();
        test_branch();
        test_kill();
        test_mem();
        test_stall();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/exec_pkg.sv
rtl/alu_unit.sv
rtl/branch_control.sv
rtl/store_align.sv
rtl/execute_stage.sv
verification/tb_execute_stage.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  # Shared package first, then the units and the top level
  - files:
      - rtl/exec_pkg.sv
      - rtl/alu_unit.sv
      - rtl/branch_control.sv
      - rtl/store_align.sv
      - rtl/execute_stage.sv

  - target: test
    files:
      - verification/tb_execute_stage.sv
